/* logic/cache_geometry_pkg.sv */
// ======================================================================
// Fixed geometry: 8 sets, 128-bit lines, 12-bit line addresses
// ======================================================================
`default_nettype none

package cache_geometry_pkg;

    localparam int TAG_W       = 9;
    localparam int INDEX_W     = 3;
    localparam int LINE_ADDR_W = TAG_W + INDEX_W;
    localparam int LINE_W      = 128;
    localparam int NUM_BYTES   = LINE_W / 8;
    localparam int NUM_SETS    = 1 << INDEX_W;

    typedef logic [TAG_W-1:0]     tag_t;
    typedef logic [INDEX_W-1:0]   index_t;
    typedef logic [LINE_W-1:0]    line_t;
    typedef logic [NUM_BYTES-1:0] byte_sel_t;

    // Line address as one word, or split into tag and set index
    typedef union packed {
        logic [LINE_ADDR_W-1:0] raw;
        struct packed {
            tag_t   tag;
            index_t index;
        } fields;
    } line_addr_u;

endpackage

`default_nettype wire

/* logic/wishbone_pkg.sv */
// ======================================================================
// Single-beat Wishbone only: no bursts, no ERR or RTY
// ======================================================================
`default_nettype none

package wishbone_pkg;

    // Master to slave
    typedef struct packed {
        logic                           cyc;
        logic                           stb;
        logic                           we;
        cache_geometry_pkg::line_addr_u adr;
        cache_geometry_pkg::byte_sel_t  sel;
        cache_geometry_pkg::line_t      dat;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic                      ack;
        cache_geometry_pkg::line_t dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

/* logic/cache_way.sv */
// ======================================================================
// One way of 8 lines; tag and data arrays have no reset
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module cache_way (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire                                 load,
    input  wire                                 fill,
    input  wire  cache_geometry_pkg::byte_sel_t  byte_sel,
    input  wire  cache_geometry_pkg::line_addr_u addr,
    input  wire  cache_geometry_pkg::line_t      data_in,
    output cache_geometry_pkg::line_t            data_out,
    output cache_geometry_pkg::tag_t             tag_out,
    output logic                                dirty_out,
    output logic                                hit
);
    import cache_geometry_pkg::*;

    logic [NUM_SETS-1:0] valid_q;
    logic [NUM_SETS-1:0] dirty_q;
    tag_t                tag_mem  [NUM_SETS];
    line_t               data_mem [NUM_SETS];
    index_t              index;
    line_t               merged;

    assign index = addr.fields.index;

    // Overlay the enabled bytes on the stored line
    always_comb begin
        merged = data_mem[index];
        for (int b = 0; b < NUM_BYTES; b++) begin
            if (byte_sel[b]) begin
                merged[8*b +: 8] = data_in[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (load) begin
            valid_q[index] <= 1'b1;
            // Fills arrive clean, CPU writes make the line dirty
            dirty_q[index] <= ~fill;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            tag_mem[index]  <= addr.fields.tag;
            data_mem[index] <= merged;
        end
    end

    assign data_out  = data_mem[index];
    assign tag_out   = tag_mem[index];
    assign dirty_out = dirty_q[index];
    assign hit       = valid_q[index] && (tag_mem[index] == addr.fields.tag);

endmodule

`default_nettype wire

/* logic/cache_lru.sv */
// ======================================================================
// Replacement state per set; ASSOCIATIVITY of 2 or 4 only
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module cache_lru #(
    parameter  int ASSOCIATIVITY = 2,
    localparam int WAY_W         = $clog2(ASSOCIATIVITY)
) (
    input  wire                             clk,
    input  wire                             reset,
    input  wire cache_geometry_pkg::index_t index,
    input  wire [WAY_W-1:0]                 mru_way,
    input  wire                             load,
    output logic [WAY_W-1:0]                lru_way
);
    import cache_geometry_pkg::*;

    if (ASSOCIATIVITY == 2) begin : g_two_way
        logic [NUM_SETS-1:0] mru_q;

        always_ff @(posedge clk) begin
            if (reset) begin
                mru_q <= '0;
            end else if (load) begin
                mru_q[index] <= mru_way;
            end
        end

        // Victim is simply the other way
        assign lru_way = ~mru_q[index];
    end else begin : g_tree
        // Bit 0 picks a half, bits 1 and 2 pick within ways 0/1 and 2/3
        logic [NUM_SETS-1:0][2:0] tree_q;
        logic [2:0]               tree_next;
        logic [2:0]               tree;

        assign tree = tree_q[index];

        // Point every node on the used path away from it
        always_comb begin
            tree_next    = tree;
            tree_next[0] = ~mru_way[1];
            if (mru_way[1]) begin
                tree_next[2] = ~mru_way[0];
            end else begin
                tree_next[1] = ~mru_way[0];
            end
        end

        always_ff @(posedge clk) begin
            if (reset) begin
                tree_q <= '0;
            end else if (load) begin
                tree_q[index] <= tree_next;
            end
        end

        assign lru_way = tree[0] ? {1'b1, tree[2]} : {1'b0, tree[1]};
    end

endmodule

`default_nettype wire

/* logic/cache_datapath.sv */
// ======================================================================
// Way array plus muxing; memory transfers always use all byte lanes
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module cache_datapath #(
    parameter  int ASSOCIATIVITY = 2,
    localparam int WAY_W         = $clog2(ASSOCIATIVITY)
) (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire  [WAY_W-1:0]                    way_sel,
    input  wire                                 fill_sel,
    input  wire                                 tag_bypass,
    input  wire                                 load,
    input  wire                                 load_lru,
    input  wire  cache_geometry_pkg::line_addr_u cpu_adr,
    input  wire  cache_geometry_pkg::byte_sel_t  cpu_sel,
    input  wire  cache_geometry_pkg::line_t      cpu_dat,
    input  wire  cache_geometry_pkg::line_t      mem_dat,
    output logic [ASSOCIATIVITY-1:0]            hit,
    output logic                                victim_dirty,
    output logic [WAY_W-1:0]                    lru_way,
    output cache_geometry_pkg::line_t            rd_dat,
    output cache_geometry_pkg::line_addr_u       mem_adr,
    output cache_geometry_pkg::byte_sel_t        mem_sel
);
    import cache_geometry_pkg::*;

    line_t                    wr_dat;
    byte_sel_t                wr_sel;
    logic [ASSOCIATIVITY-1:0] way_load;
    line_t                    way_dat [ASSOCIATIVITY];
    tag_t                     way_tag [ASSOCIATIVITY];
    logic [ASSOCIATIVITY-1:0] way_dirty;
    tag_t                     mem_tag;

    assign mem_sel = '1;

    // Fill data covers the whole line
    assign wr_dat = fill_sel ? mem_dat : cpu_dat;
    assign wr_sel = fill_sel ? mem_sel : cpu_sel;

    // Only the selected way sees the write strobe
    always_comb begin
        way_load          = '0;
        way_load[way_sel] = load;
    end

    assign rd_dat       = way_dat[way_sel];
    assign victim_dirty = way_dirty[lru_way];

    // Writeback goes to the victim's own tag, a fill to the request tag
    assign mem_tag     = tag_bypass ? cpu_adr.fields.tag : way_tag[way_sel];
    assign mem_adr.raw = {mem_tag, cpu_adr.fields.index};

    for (genvar w = 0; w < ASSOCIATIVITY; w++) begin : g_way
        cache_way u_way (
            .clk       (clk),
            .reset     (reset),
            .load      (way_load[w]),
            .fill      (fill_sel),
            .byte_sel  (wr_sel),
            .addr      (cpu_adr),
            .data_in   (wr_dat),
            .data_out  (way_dat[w]),
            .tag_out   (way_tag[w]),
            .dirty_out (way_dirty[w]),
            .hit       (hit[w])
        );
    end

    cache_lru #(
        .ASSOCIATIVITY (ASSOCIATIVITY)
    ) u_lru (
        .clk     (clk),
        .reset   (reset),
        .index   (cpu_adr.fields.index),
        .mru_way (way_sel),
        .load    (load_lru),
        .lru_way (lru_way)
    );

endmodule

`default_nettype wire

/* logic/cache_controller.sv */
// ======================================================================
// CPU request must stay stable until ack; one outstanding access
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module cache_controller #(
    parameter  int ASSOCIATIVITY = 2,
    localparam int WAY_W         = $clog2(ASSOCIATIVITY)
) (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      cpu_cyc,
    input  wire                      cpu_stb,
    input  wire                      cpu_we,
    input  wire                      mem_ack,
    input  wire  [ASSOCIATIVITY-1:0] hit,
    input  wire                      victim_dirty,
    input  wire  [WAY_W-1:0]         lru_way,
    output logic [WAY_W-1:0]         way_sel,
    output logic                     fill_sel,
    output logic                     tag_bypass,
    output logic                     load,
    output logic                     load_lru,
    output logic                     cpu_ack,
    output logic                     mem_cyc,
    output logic                     mem_stb,
    output logic                     mem_we
);

    typedef enum logic [1:0] {
        IDLE,
        COMPARE,
        WRITEBACK,
        FILL
    } state_t;

    state_t           state;
    state_t           state_next;
    logic [WAY_W-1:0] hit_way;
    logic             hit_any;

    // At most one way can match
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < ASSOCIATIVITY; w++) begin
            if (hit[w]) begin
                hit_way = WAY_W'(w);
            end
        end
    end

    assign hit_any = |hit;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        way_sel    = lru_way;
        fill_sel   = 1'b0;
        tag_bypass = 1'b0;
        load       = 1'b0;
        load_lru   = 1'b0;
        cpu_ack    = 1'b0;
        mem_cyc    = 1'b0;
        mem_stb    = 1'b0;
        mem_we     = 1'b0;
        case (state)
            IDLE: begin
                if (cpu_cyc && cpu_stb) begin
                    state_next = COMPARE;
                end
            end
            COMPARE: begin
                if (hit_any) begin
                    way_sel    = hit_way;
                    cpu_ack    = 1'b1;
                    load       = cpu_we;
                    load_lru   = 1'b1;
                    state_next = IDLE;
                end else if (victim_dirty) begin
                    state_next = WRITEBACK;
                end else begin
                    state_next = FILL;
                end
            end
            WRITEBACK: begin
                mem_cyc = 1'b1;
                mem_stb = 1'b1;
                mem_we  = 1'b1;
                if (mem_ack) begin
                    state_next = FILL;
                end
            end
            FILL: begin
                mem_cyc    = 1'b1;
                mem_stb    = 1'b1;
                tag_bypass = 1'b1;
                if (mem_ack) begin
                    load       = 1'b1;
                    fill_sel   = 1'b1;
                    // Back to COMPARE, which now hits
                    state_next = COMPARE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

endmodule

`default_nettype wire

/* logic/cache_top.sv */
// ======================================================================
// Write-back cache between two Wishbone ports; ASSOCIATIVITY 2 or 4
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module cache_top #(
    parameter  int ASSOCIATIVITY = 2,
    localparam int WAY_W         = $clog2(ASSOCIATIVITY)
) (
    input  wire                          clk,
    input  wire                          reset,
    input  wire  wishbone_pkg::wb_req_t  cpu_req,
    output wishbone_pkg::wb_rsp_t        cpu_rsp,
    output wishbone_pkg::wb_req_t        mem_req,
    input  wire  wishbone_pkg::wb_rsp_t  mem_rsp
);
    import cache_geometry_pkg::*;

    logic [ASSOCIATIVITY-1:0] hit;
    logic                     victim_dirty;
    logic [WAY_W-1:0]         lru_way;
    logic [WAY_W-1:0]         way_sel;
    logic                     fill_sel;
    logic                     tag_bypass;
    logic                     load;
    logic                     load_lru;
    logic                     cpu_ack;
    logic                     mem_cyc;
    logic                     mem_stb;
    logic                     mem_we;
    line_t                    rd_dat;
    line_addr_u               mem_adr;
    byte_sel_t                mem_sel;

    // Read data serves both the CPU and writebacks
    assign cpu_rsp = '{ack: cpu_ack, dat: rd_dat};
    assign mem_req = '{cyc: mem_cyc, stb: mem_stb, we: mem_we,
                       adr: mem_adr, sel: mem_sel, dat: rd_dat};

    cache_controller #(
        .ASSOCIATIVITY (ASSOCIATIVITY)
    ) u_controller (
        .clk          (clk),
        .reset        (reset),
        .cpu_cyc      (cpu_req.cyc),
        .cpu_stb      (cpu_req.stb),
        .cpu_we       (cpu_req.we),
        .mem_ack      (mem_rsp.ack),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .lru_way      (lru_way),
        .way_sel      (way_sel),
        .fill_sel     (fill_sel),
        .tag_bypass   (tag_bypass),
        .load         (load),
        .load_lru     (load_lru),
        .cpu_ack      (cpu_ack),
        .mem_cyc      (mem_cyc),
        .mem_stb      (mem_stb),
        .mem_we       (mem_we)
    );

    cache_datapath #(
        .ASSOCIATIVITY (ASSOCIATIVITY)
    ) u_datapath (
        .clk          (clk),
        .reset        (reset),
        .way_sel      (way_sel),
        .fill_sel     (fill_sel),
        .tag_bypass   (tag_bypass),
        .load         (load),
        .load_lru     (load_lru),
        .cpu_adr      (cpu_req.adr),
        .cpu_sel      (cpu_req.sel),
        .cpu_dat      (cpu_req.dat),
        .mem_dat      (mem_rsp.dat),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .lru_way      (lru_way),
        .rd_dat       (rd_dat),
        .mem_adr      (mem_adr),
        .mem_sel      (mem_sel)
    );

endmodule

`default_nettype wire

/* tests/cache_tb.sv */
// ======================================================================
// Drives cache_top with 2 ways against a memory model with random ack delay
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module cache_tb;
    import cache_geometry_pkg::*;
    import wishbone_pkg::*;

    localparam int NUM_ROWS   = 14;
    localparam int ROW_CYCLES = 20;
    localparam int ACK_LIMIT  = 16;

    typedef struct {
        string      name;
        logic       we;
        line_addr_u adr;
        byte_sel_t  sel;
        line_t      dat;
        logic       traffic;
    } row_t;

    logic       clk;
    logic       reset;
    wb_req_t    cpu_req;
    wb_rsp_t    cpu_rsp;
    wb_req_t    mem_req;
    wb_rsp_t    mem_rsp = '0;

    row_t       rows [NUM_ROWS];
    int         error_count = 0;
    logic [31:0] lcg_state = 32'h5d8;

    // Memory model state and traffic log
    line_t      mem_store [int];
    int         wait_left = 0;
    int         read_count = 0;
    int         write_count = 0;
    line_addr_u last_read_adr;
    line_t      last_wb_dat;
    line_addr_u wb_log [$];
    // AND of the byte selects over one row's memory transfers
    byte_sel_t  sel_seen = '1;

    // Shadow 2-way cache and memory
    line_t      sh_mem [int];
    logic       sh_valid [NUM_SETS][2];
    logic       sh_dirty [NUM_SETS][2];
    tag_t       sh_tag   [NUM_SETS][2];
    line_t      sh_data  [NUM_SETS][2];
    logic       sh_mru   [NUM_SETS];

    cache_top #(
        .ASSOCIATIVITY (2)
    ) dut (
        .clk     (clk),
        .reset   (reset),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Power-up content is the line address repeated over the whole line
    function automatic line_t initial_line(input logic [LINE_ADDR_W-1:0] a);
        line_t l;
        for (int i = 0; i < LINE_W; i++) begin
            l[i] = a[i % LINE_ADDR_W];
        end
        return l;
    endfunction

    function automatic line_t model_read(input logic [LINE_ADDR_W-1:0] a);
        if (mem_store.exists(int'(a))) begin
            return mem_store[int'(a)];
        end
        return initial_line(a);
    endfunction

    function automatic line_t shadow_read(input logic [LINE_ADDR_W-1:0] a);
        if (sh_mem.exists(int'(a))) begin
            return sh_mem[int'(a)];
        end
        return initial_line(a);
    endfunction

    function automatic int next_delay();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[17:16]);
    endfunction

    // Memory slave acks for one cycle after a wait of 0 to 3 cycles
    always @(negedge clk) begin
        if (mem_rsp.ack) begin
            mem_rsp.ack <= 1'b0;
        end else if (mem_req.cyc && mem_req.stb) begin
            if (wait_left > 0) begin
                wait_left <= wait_left - 1;
            end else begin
                sel_seen = sel_seen & mem_req.sel;
                if (mem_req.we) begin
                    mem_store[int'(mem_req.adr.raw)] = mem_req.dat;
                    write_count++;
                    wb_log.push_back(mem_req.adr);
                    last_wb_dat = mem_req.dat;
                end else begin
                    mem_rsp.dat <= model_read(mem_req.adr.raw);
                    read_count++;
                    last_read_adr = mem_req.adr;
                end
                mem_rsp.ack <= 1'b1;
                wait_left   <= next_delay();
            end
        end
    end

    task automatic compare_line(input string name, input line_t exp, input line_t act);
        if (exp !== act) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            error_count++;
        end
    endtask

    task automatic compare_addr(input string name, input line_addr_u exp,
                                input line_addr_u act);
        if (exp.raw !== act.raw) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp.raw, act.raw);
            error_count++;
        end
    endtask

    task automatic compare_sel(input string name, input byte_sel_t exp,
                               input byte_sel_t act);
        if (exp !== act) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            error_count++;
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Mismatch %s: expected %0b, actual %0b", name, exp, act);
            error_count++;
        end
    endtask

    task automatic set_row(input int i, input string name, input logic we,
                           input logic [LINE_ADDR_W-1:0] adr, input byte_sel_t sel,
                           input line_t dat, input logic traffic);
        rows[i].name    = name;
        rows[i].we      = we;
        rows[i].adr.raw = adr;
        rows[i].sel     = sel;
        rows[i].dat     = dat;
        rows[i].traffic = traffic;
    endtask

    // Set 5 holds tags 012 (A), 034 (B) and 056 (C) in turn
    task automatic fill_table();
        set_row(0, "rd_cold_a", 1'b0, 12'h095, '0, '0, 1'b1);
        set_row(1, "rd_hit_a", 1'b0, 12'h095, '0, '0, 1'b0);
        set_row(2, "wr_part_a", 1'b1, 12'h095, 16'h00f0, {4{32'hcafe_f00d}}, 1'b0);
        set_row(3, "rd_merged_a", 1'b0, 12'h095, '0, '0, 1'b0);
        set_row(4, "rd_miss_b", 1'b0, 12'h1a5, '0, '0, 1'b1);
        set_row(5, "rd_evict_a", 1'b0, 12'h2b5, '0, '0, 1'b1);
        set_row(6, "rd_back_a", 1'b0, 12'h095, '0, '0, 1'b1);
        set_row(7, "rd_touch_c", 1'b0, 12'h2b5, '0, '0, 1'b0);
        set_row(8, "rd_miss_b2", 1'b0, 12'h1a5, '0, '0, 1'b1);
        set_row(9, "rd_hit_c", 1'b0, 12'h2b5, '0, '0, 1'b0);
        set_row(10, "rd_miss_a", 1'b0, 12'h095, '0, '0, 1'b1);
        set_row(11, "rd_cold_far", 1'b0, 12'hffa, '0, '0, 1'b1);
        set_row(12, "wr_miss_e", 1'b1, 12'h0f1, 16'hff00, {8{16'h1234}}, 1'b1);
        set_row(13, "rd_e", 1'b0, 12'h0f1, '0, '0, 1'b0);
    endtask

    // Victim is the way not used last and goes back to memory if dirty
    task automatic shadow_access(input row_t row, output line_t exp_dat, output logic miss,
                                 output logic wb, output line_addr_u wb_adr,
                                 output line_t wb_dat);
        index_t idx;
        tag_t   tag;
        int     w;
        idx    = row.adr.fields.index;
        tag    = row.adr.fields.tag;
        miss   = 1'b1;
        wb     = 1'b0;
        wb_adr = '0;
        wb_dat = '0;
        w      = sh_mru[idx] ? 0 : 1;
        for (int k = 0; k < 2; k++) begin
            if (sh_valid[idx][k] && sh_tag[idx][k] == tag) begin
                miss = 1'b0;
                w    = k;
            end
        end
        if (miss) begin
            if (sh_valid[idx][w] && sh_dirty[idx][w]) begin
                wb         = 1'b1;
                wb_adr.raw = {sh_tag[idx][w], idx};
                wb_dat     = sh_data[idx][w];
                sh_mem[int'(wb_adr.raw)] = wb_dat;
            end
            sh_data[idx][w]  = shadow_read(row.adr.raw);
            sh_tag[idx][w]   = tag;
            sh_valid[idx][w] = 1'b1;
            sh_dirty[idx][w] = 1'b0;
        end
        if (row.we) begin
            for (int b = 0; b < NUM_BYTES; b++) begin
                if (row.sel[b]) begin
                    sh_data[idx][w][8*b +: 8] = row.dat[8*b +: 8];
                end
            end
            sh_dirty[idx][w] = 1'b1;
        end
        exp_dat     = sh_data[idx][w];
        sh_mru[idx] = (w == 1);
    endtask

    task automatic apply_row(input row_t row, output logic acked, output line_t rd_line);
        wb_req_t req;
        int      cycles;
        req     = '0;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = row.we;
        req.adr = row.adr;
        req.sel = row.sel;
        req.dat = row.dat;
        acked   = 1'b0;
        rd_line = '0;
        cycles  = 0;
        @(negedge clk);
        cpu_req <= req;
        while (!acked && cycles < ACK_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (cpu_rsp.ack) begin
                acked   = 1'b1;
                rd_line = cpu_rsp.dat;
            end
        end
        // Ack completes at the coming rising edge
        @(negedge clk);
        cpu_req <= '0;
    endtask

    initial begin
        repeat (NUM_ROWS * ROW_CYCLES) @(posedge clk);
        $display("Timeout: run exceeded %0d clock cycles", NUM_ROWS * ROW_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        logic       acked;
        logic       exp_miss;
        logic       exp_wb;
        line_t      rd_line;
        line_t      exp_dat;
        line_t      exp_wb_dat;
        line_addr_u exp_wb_adr;
        int         reads_before;
        int         writes_before;
        int         read_delta;
        int         write_delta;
        int         errors_before;
        int         failed_rows;
        cpu_req     = '0;
        reset       = 1'b1;
        failed_rows = 0;
        for (int s = 0; s < NUM_SETS; s++) begin
            sh_mru[s] = 1'b0;
            for (int k = 0; k < 2; k++) begin
                sh_valid[s][k] = 1'b0;
                sh_dirty[s][k] = 1'b0;
            end
        end
        fill_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset <= 1'b0;
        @(negedge clk);
        compare_flag("reset_idle", 1'b0, cpu_rsp.ack | mem_req.cyc | mem_req.stb);

        for (int i = 0; i < NUM_ROWS; i++) begin
            errors_before = error_count;
            reads_before  = read_count;
            writes_before = write_count;
            sel_seen      = '1;
            shadow_access(rows[i], exp_dat, exp_miss, exp_wb, exp_wb_adr, exp_wb_dat);
            apply_row(rows[i], acked, rd_line);
            read_delta  = read_count - reads_before;
            write_delta = write_count - writes_before;
            if (!acked) begin
                $display("Row %s got no ack from the cache within %0d cycles",
                         rows[i].name, ACK_LIMIT);
                error_count++;
            end else begin
                if (!rows[i].we) begin
                    compare_line({rows[i].name, " data"}, exp_dat, rd_line);
                end
                compare_flag({rows[i].name, " traffic"}, rows[i].traffic,
                             (read_delta + write_delta) != 0);
                compare_flag({rows[i].name, " fill"}, exp_miss, read_delta == 1);
                compare_flag({rows[i].name, " writeback"}, exp_wb, write_delta == 1);
                if ((read_delta + write_delta) != 0) begin
                    compare_sel({rows[i].name, " mem sel"}, '1, sel_seen);
                end
                if (exp_miss && read_delta == 1) begin
                    compare_addr({rows[i].name, " fill addr"}, rows[i].adr, last_read_adr);
                end
                if (exp_wb && write_delta == 1) begin
                    compare_addr({rows[i].name, " wb addr"}, exp_wb_adr, wb_log[$]);
                    compare_line({rows[i].name, " wb data"}, exp_wb_dat, last_wb_dat);
                end
            end
            if (error_count != errors_before) begin
                failed_rows++;
            end
            $display("Row %0d %s: %s", i, rows[i].name,
                     (error_count == errors_before) ? "ok" : "FAILED");
        end

        $display("Rows run: %0d, rows failed: %0d, checks failed: %0d",
                 NUM_ROWS, failed_rows, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
logic/cache_geometry_pkg.sv
logic/wishbone_pkg.sv
logic/cache_way.sv
logic/cache_lru.sv
logic/cache_datapath.sv
logic/cache_controller.sv
logic/cache_top.sv
tests/cache_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := cache_tb
FILELIST  := filelist.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^All tests passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
